// ==== rtl/exu_cfg.svh ====
`ifndef EXU_CFG_SVH
`define EXU_CFG_SVH

// datapath width
`define EXU_XLEN 32

// machine mode csr addresses
`define EXU_CSR_MSTATUS  12'h300
`define EXU_CSR_MTVEC    12'h305
`define EXU_CSR_MSCRATCH 12'h340
`define EXU_CSR_MEPC     12'h341
`define EXU_CSR_MCAUSE   12'h342

// environment call from m-mode
`define EXU_MCAUSE_ECALL 11

// trap vector after reset
`define EXU_MTVEC_RESET 'h100

// data memory
`define EXU_MEM_WORDS 256
`define EXU_MEM_LAT   3

`endif

// ==== rtl/exu_pkg.sv ====
`default_nettype none

`include "exu_cfg.svh"

package exu_pkg;

  typedef logic [`EXU_XLEN-1:0] word_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [11:0] csr_addr_t;

  typedef enum logic [3:0] {
    KIND_ALU,
    KIND_BRANCH,
    KIND_JAL,
    KIND_JALR,
    KIND_LOAD,
    KIND_STORE,
    KIND_CSR,
    KIND_ECALL,
    KIND_MRET
  } exu_kind_e;

  // branches reuse SUB, XOR and the compares
  typedef enum logic [3:0] {
    ADD, SUB, XOR, OR, AND, SLL, SRL, SRA, SLT, SLTU, SGE, SGEU
  } alu_op_e;

  typedef enum logic [1:0] {
    CSR_RW,
    CSR_RS,
    CSR_RC
  } csr_op_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_MEM_REQ,
    ST_MEM_WAIT,
    ST_DONE
  } stage_state_e;

endpackage

`default_nettype wire

// ==== rtl/exu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exu_cfg.svh"

module exu_alu import exu_pkg::*; (
  input  word_t   src1_i,
  input  word_t   src2_i,
  input  alu_op_e op_i,
  output word_t   res_o
);

  localparam int SHW = $clog2(`EXU_XLEN);

  logic [SHW-1:0] shamt;
  logic lt_s;
  logic lt_u;

  assign shamt = src2_i[SHW-1:0];
  assign lt_s = $signed(src1_i) < $signed(src2_i);
  assign lt_u = src1_i < src2_i;

  always_comb begin
    case (op_i)
      ADD:     res_o = src1_i + src2_i;
      SUB:     res_o = src1_i - src2_i;
      XOR:     res_o = src1_i ^ src2_i;
      OR:      res_o = src1_i | src2_i;
      AND:     res_o = src1_i & src2_i;
      SLL:     res_o = src1_i << shamt;
      SRL:     res_o = src1_i >> shamt;
      SRA:     res_o = word_t'($signed(src1_i) >>> shamt);
      // compares give 0 or 1
      SLT:     res_o = word_t'(lt_s);
      SLTU:    res_o = word_t'(lt_u);
      SGE:     res_o = word_t'(!lt_s);
      SGEU:    res_o = word_t'(!lt_u);
      default: res_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/exu_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exu_cfg.svh"

module exu_csr import exu_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  csr_addr_t raddr_i,
  output word_t     rdata_o,
  input  logic      we_i,
  input  csr_addr_t waddr_i,
  input  word_t     wdata_i,
  input  logic      ecall_i,
  input  word_t     epc_i,
  input  logic      mret_i,
  output word_t     mtvec_o,
  output word_t     mepc_o
);

  word_t mstatus_q;
  word_t mtvec_q;
  word_t mepc_q;
  word_t mcause_q;
  word_t mscratch_q;

  always_comb begin
    case (raddr_i)
      `EXU_CSR_MSTATUS:  rdata_o = mstatus_q;
      `EXU_CSR_MTVEC:    rdata_o = mtvec_q;
      `EXU_CSR_MEPC:     rdata_o = mepc_q;
      `EXU_CSR_MCAUSE:   rdata_o = mcause_q;
      `EXU_CSR_MSCRATCH: rdata_o = mscratch_q;
      default:           rdata_o = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q  <= '0;
      mtvec_q    <= word_t'(`EXU_MTVEC_RESET);
      mepc_q     <= '0;
      mcause_q   <= '0;
      mscratch_q <= '0;
    end else begin
      if (we_i) begin
        case (waddr_i)
          `EXU_CSR_MSTATUS:  mstatus_q <= wdata_i;
          `EXU_CSR_MTVEC:    mtvec_q <= wdata_i;
          `EXU_CSR_MEPC:     mepc_q <= wdata_i;
          `EXU_CSR_MCAUSE:   mcause_q <= wdata_i;
          `EXU_CSR_MSCRATCH: mscratch_q <= wdata_i;
          default:           mscratch_q <= mscratch_q;
        endcase
      end
      if (ecall_i) begin
        mepc_q   <= epc_i;
        mcause_q <= word_t'(`EXU_MCAUSE_ECALL);
      end
      // mie <= mpie, mpie <= 1
      if (mret_i) begin
        mstatus_q[3] <= mstatus_q[7];
        mstatus_q[7] <= 1'b1;
      end
    end
  end

  assign mtvec_o = mtvec_q;
  assign mepc_o  = mepc_q;

  // stage retires one operation at a time
  a_ecall_mret_excl: assert property (
    @(posedge clk) disable iff (rst) !(ecall_i && mret_i)
  );

  a_pulse_no_write: assert property (
    @(posedge clk) disable iff (rst) (ecall_i || mret_i) |-> !we_i
  );

endmodule

`default_nettype wire

// ==== rtl/exu_data_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exu_cfg.svh"

module exu_data_mem import exu_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  req_i,
  input  logic  we_i,
  input  word_t addr_i,
  input  word_t wdata_i,
  output logic  rvalid_o,
  output word_t rdata_o
);

  localparam int LAT = `EXU_MEM_LAT;
  localparam int AW  = $clog2(`EXU_MEM_WORDS);

  word_t mem [`EXU_MEM_WORDS];

  logic [LAT-1:0] vld_q;
  logic [LAT-1:0] we_q;
  logic [AW-1:0]  idx_q [LAT];
  word_t          wdata_q [LAT];
  logic [AW-1:0]  idx_out;

  initial begin
    for (int i = 0; i < `EXU_MEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= req_i;
      for (int i = 1; i < LAT; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    we_q[0]    <= we_i;
    idx_q[0]   <= addr_i[AW+1:2];
    wdata_q[0] <= wdata_i;
    for (int i = 1; i < LAT; i++) begin
      we_q[i]    <= we_q[i-1];
      idx_q[i]   <= idx_q[i-1];
      wdata_q[i] <= wdata_q[i-1];
    end
  end

  // access happens at the tail of the delay line
  assign idx_out  = idx_q[LAT-1];
  assign rvalid_o = vld_q[LAT-1];
  assign rdata_o  = mem[idx_out];

  always @(posedge clk) begin
    if (vld_q[LAT-1] && we_q[LAT-1]) begin
      mem[idx_out] <= wdata_q[LAT-1];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/exu_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exu_cfg.svh"

module exu_stage import exu_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      in_valid_i,
  output logic      in_ready_o,
  input  word_t     pc_i,
  input  word_t     src1_i,
  input  word_t     src2_i,
  input  word_t     imm_i,
  input  exu_kind_e kind_i,
  input  alu_op_e   alu_op_i,
  input  csr_op_e   csr_op_i,
  input  csr_addr_t csr_addr_i,
  input  reg_idx_t  rd_i,
  output logic      out_valid_o,
  input  logic      out_ready_i,
  output reg_idx_t  rd_o,
  output word_t     rd_wdata_o,
  output logic      redirect_o,
  output word_t     npc_o,
  output logic      mem_req_o,
  output logic      mem_we_o,
  output word_t     mem_addr_o,
  output word_t     mem_wdata_o,
  input  logic      mem_rvalid_i,
  input  word_t     mem_rdata_i,
  output csr_addr_t csr_raddr_o,
  input  word_t     csr_rdata_i,
  output logic      csr_we_o,
  output csr_addr_t csr_waddr_o,
  output word_t     csr_wdata_o,
  output logic      ecall_pulse_o,
  output word_t     epc_o,
  output logic      mret_pulse_o,
  input  word_t     mtvec_i,
  input  word_t     mepc_i
);

  stage_state_e state_q;
  logic mem_req_q;

  word_t pc_q, src1_q, src2_q, imm_q;
  word_t mem_rdata_q;
  exu_kind_e kind_q;
  alu_op_e alu_op_q;
  csr_op_e csr_op_q;
  csr_addr_t csr_addr_q;
  reg_idx_t rd_q;

  logic in_fire, out_fire, in_is_mem;
  logic wb_en, branch_taken;
  word_t alu_res, pc_plus4, target, agen, wb_data;

  assign out_valid_o = state_q == ST_DONE;
  assign out_fire    = out_valid_o && out_ready_i;
  assign in_ready_o  = state_q == ST_IDLE || out_fire;
  assign in_fire     = in_valid_i && in_ready_o;
  assign in_is_mem   = kind_i == KIND_LOAD || kind_i == KIND_STORE;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= ST_IDLE;
      mem_req_q <= 1'b0;
    end else begin
      // request leaves one cycle after acceptance
      mem_req_q <= in_fire && in_is_mem;
      if (in_fire) begin
        state_q <= in_is_mem ? ST_MEM_REQ : ST_DONE;
      end else begin
        case (state_q)
          ST_MEM_REQ:  state_q <= ST_MEM_WAIT;
          ST_MEM_WAIT: if (mem_rvalid_i) state_q <= ST_DONE;
          ST_DONE:     if (out_ready_i) state_q <= ST_IDLE;
          default:     state_q <= ST_IDLE;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      pc_q       <= pc_i;
      src1_q     <= src1_i;
      src2_q     <= src2_i;
      imm_q      <= imm_i;
      kind_q     <= kind_i;
      alu_op_q   <= alu_op_i;
      csr_op_q   <= csr_op_i;
      csr_addr_q <= csr_addr_i;
      rd_q       <= rd_i;
    end
    if (state_q == ST_MEM_WAIT && mem_rvalid_i) begin
      mem_rdata_q <= mem_rdata_i;
    end
  end

  exu_alu u_alu (
    .src1_i (src1_q),
    .src2_i (src2_q),
    .op_i   (alu_op_q),
    .res_o  (alu_res)
  );

  assign pc_plus4 = pc_q + word_t'(4);
  assign target   = pc_q + imm_q;
  assign agen     = src1_q + imm_q;

  // beq via SUB, bne via XOR, the rest via compares
  always_comb begin
    case (alu_op_q)
      SUB:                       branch_taken = alu_res == '0;
      XOR, SLT, SLTU, SGE, SGEU: branch_taken = alu_res != '0;
      default:                   branch_taken = 1'b0;
    endcase
  end

  always_comb begin
    wb_en      = 1'b0;
    wb_data    = alu_res;
    redirect_o = 1'b0;
    npc_o      = pc_plus4;
    case (kind_q)
      KIND_ALU: wb_en = 1'b1;
      KIND_BRANCH: begin
        redirect_o = branch_taken;
        if (branch_taken) begin
          npc_o = target;
        end
      end
      KIND_JAL: begin
        wb_en      = 1'b1;
        wb_data    = pc_plus4;
        redirect_o = 1'b1;
        npc_o      = target;
      end
      KIND_JALR: begin
        wb_en      = 1'b1;
        wb_data    = pc_plus4;
        redirect_o = 1'b1;
        npc_o      = agen & ~word_t'(1);
      end
      KIND_LOAD: begin
        wb_en   = 1'b1;
        wb_data = mem_rdata_q;
      end
      KIND_CSR: begin
        wb_en   = 1'b1;
        wb_data = csr_rdata_i;
      end
      KIND_ECALL: begin
        redirect_o = 1'b1;
        npc_o      = mtvec_i;
      end
      KIND_MRET: begin
        redirect_o = 1'b1;
        npc_o      = mepc_i;
      end
      default: wb_en = 1'b0;
    endcase
  end

  assign rd_o       = wb_en ? rd_q : '0;
  assign rd_wdata_o = {`EXU_XLEN{rd_o != '0}} & wb_data;

  // read-modify-write on the old csr value
  always_comb begin
    case (csr_op_q)
      CSR_RS:  csr_wdata_o = csr_rdata_i | src1_q;
      CSR_RC:  csr_wdata_o = csr_rdata_i & ~src1_q;
      default: csr_wdata_o = src1_q;
    endcase
  end

  assign csr_raddr_o   = csr_addr_q;
  assign csr_waddr_o   = csr_addr_q;
  assign csr_we_o      = out_fire && kind_q == KIND_CSR;
  assign ecall_pulse_o = out_fire && kind_q == KIND_ECALL;
  assign mret_pulse_o  = out_fire && kind_q == KIND_MRET;
  assign epc_o         = pc_q;

  assign mem_req_o   = mem_req_q;
  assign mem_we_o    = kind_q == KIND_STORE;
  assign mem_addr_o  = agen;
  assign mem_wdata_o = src2_q;

  // every answer belongs to a request made a fixed latency earlier
  a_rvalid_after_req: assert property (
    @(posedge clk) disable iff (rst) mem_rvalid_i |-> $past(mem_req_o, `EXU_MEM_LAT)
  );

endmodule

`default_nettype wire

// ==== rtl/exu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_top import exu_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      in_valid_i,
  output logic      in_ready_o,
  input  word_t     pc_i,
  input  word_t     src1_i,
  input  word_t     src2_i,
  input  word_t     imm_i,
  input  exu_kind_e kind_i,
  input  alu_op_e   alu_op_i,
  input  csr_op_e   csr_op_i,
  input  csr_addr_t csr_addr_i,
  input  reg_idx_t  rd_i,
  output logic      out_valid_o,
  input  logic      out_ready_i,
  output reg_idx_t  rd_o,
  output word_t     rd_wdata_o,
  output logic      redirect_o,
  output word_t     npc_o
);

  logic mem_req, mem_we, mem_rvalid;
  word_t mem_addr, mem_wdata, mem_rdata;

  logic csr_we, ecall_pulse, mret_pulse;
  csr_addr_t csr_raddr, csr_waddr;
  word_t csr_rdata, csr_wdata, epc, mtvec, mepc;

  exu_stage u_stage (
    .clk           (clk),
    .rst           (rst),
    .in_valid_i    (in_valid_i),
    .in_ready_o    (in_ready_o),
    .pc_i          (pc_i),
    .src1_i        (src1_i),
    .src2_i        (src2_i),
    .imm_i         (imm_i),
    .kind_i        (kind_i),
    .alu_op_i      (alu_op_i),
    .csr_op_i      (csr_op_i),
    .csr_addr_i    (csr_addr_i),
    .rd_i          (rd_i),
    .out_valid_o   (out_valid_o),
    .out_ready_i   (out_ready_i),
    .rd_o          (rd_o),
    .rd_wdata_o    (rd_wdata_o),
    .redirect_o    (redirect_o),
    .npc_o         (npc_o),
    .mem_req_o     (mem_req),
    .mem_we_o      (mem_we),
    .mem_addr_o    (mem_addr),
    .mem_wdata_o   (mem_wdata),
    .mem_rvalid_i  (mem_rvalid),
    .mem_rdata_i   (mem_rdata),
    .csr_raddr_o   (csr_raddr),
    .csr_rdata_i   (csr_rdata),
    .csr_we_o      (csr_we),
    .csr_waddr_o   (csr_waddr),
    .csr_wdata_o   (csr_wdata),
    .ecall_pulse_o (ecall_pulse),
    .epc_o         (epc),
    .mret_pulse_o  (mret_pulse),
    .mtvec_i       (mtvec),
    .mepc_i        (mepc)
  );

  exu_csr u_csr (
    .clk     (clk),
    .rst     (rst),
    .raddr_i (csr_raddr),
    .rdata_o (csr_rdata),
    .we_i    (csr_we),
    .waddr_i (csr_waddr),
    .wdata_i (csr_wdata),
    .ecall_i (ecall_pulse),
    .epc_i   (epc),
    .mret_i  (mret_pulse),
    .mtvec_o (mtvec),
    .mepc_o  (mepc)
  );

  exu_data_mem u_mem (
    .clk      (clk),
    .rst      (rst),
    .req_i    (mem_req),
    .we_i     (mem_we),
    .addr_i   (mem_addr),
    .wdata_i  (mem_wdata),
    .rvalid_o (mem_rvalid),
    .rdata_o  (mem_rdata)
  );

endmodule

`default_nettype wire

// ==== tests/tb_exu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exu_cfg.svh"

module tb_exu_top import exu_pkg::*; ();

  localparam int NUM_OPS = 400;
  localparam int TIMEOUT = NUM_OPS * (`EXU_MEM_LAT + 10);
  localparam int MEM_AW  = $clog2(`EXU_MEM_WORDS);

  typedef struct packed {
    word_t     pc;
    word_t     src1;
    word_t     src2;
    word_t     imm;
    exu_kind_e kind;
    alu_op_e   alu_op;
    csr_op_e   csr_op;
    csr_addr_t csr_addr;
    reg_idx_t  rd;
  } op_t;

  logic      clk;
  logic      rst;
  logic      in_valid_i;
  logic      in_ready_o;
  op_t       cur_op;
  logic      out_valid_o;
  logic      out_ready_i;
  reg_idx_t  rd_o;
  word_t     rd_wdata_o;
  logic      redirect_o;
  word_t     npc_o;

  op_t   pend_q[$];
  int    results;
  word_t mem_m [`EXU_MEM_WORDS];
  word_t mstatus_m, mtvec_m, mepc_m, mcause_m, mscratch_m;

  exu_top i_dut (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .pc_i        (cur_op.pc),
    .src1_i      (cur_op.src1),
    .src2_i      (cur_op.src2),
    .imm_i       (cur_op.imm),
    .kind_i      (cur_op.kind),
    .alu_op_i    (cur_op.alu_op),
    .csr_op_i    (cur_op.csr_op),
    .csr_addr_i  (cur_op.csr_addr),
    .rd_i        (cur_op.rd),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .rd_o        (rd_o),
    .rd_wdata_o  (rd_wdata_o),
    .redirect_o  (redirect_o),
    .npc_o       (npc_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
    end
  endtask

  function automatic word_t alu_ref(input word_t a, input word_t b, input alu_op_e op);
    case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      XOR:     return a ^ b;
      OR:      return a | b;
      AND:     return a & b;
      SLL:     return a << b[4:0];
      SRL:     return a >> b[4:0];
      SRA:     return word_t'($signed(a) >>> b[4:0]);
      SLT:     return word_t'($signed(a) < $signed(b));
      SLTU:    return word_t'(a < b);
      SGE:     return word_t'($signed(a) >= $signed(b));
      SGEU:    return word_t'(a >= b);
      default: return '0;
    endcase
  endfunction

  function automatic word_t csr_read(input csr_addr_t a);
    case (a)
      `EXU_CSR_MSTATUS:  return mstatus_m;
      `EXU_CSR_MTVEC:    return mtvec_m;
      `EXU_CSR_MEPC:     return mepc_m;
      `EXU_CSR_MCAUSE:   return mcause_m;
      `EXU_CSR_MSCRATCH: return mscratch_m;
      default:           return '0;
    endcase
  endfunction

  function automatic void csr_write(input csr_addr_t a, input word_t v);
    case (a)
      `EXU_CSR_MSTATUS:  mstatus_m = v;
      `EXU_CSR_MTVEC:    mtvec_m = v;
      `EXU_CSR_MEPC:     mepc_m = v;
      `EXU_CSR_MCAUSE:   mcause_m = v;
      `EXU_CSR_MSCRATCH: mscratch_m = v;
      default:           mscratch_m = mscratch_m;
    endcase
  endfunction

  // expected result of one retiring op and its csr and memory updates
  function automatic void exu_model(input op_t op, output reg_idx_t e_rd,
                                    output word_t e_wdata, output logic e_redir,
                                    output word_t e_npc);
    word_t res;
    word_t addr;
    word_t old;
    logic  wb;
    res     = alu_ref(op.src1, op.src2, op.alu_op);
    addr    = op.src1 + op.imm;
    wb      = 1'b0;
    e_wdata = '0;
    e_redir = 1'b0;
    e_npc   = op.pc + word_t'(4);
    case (op.kind)
      KIND_ALU: begin
        wb      = 1'b1;
        e_wdata = res;
      end
      KIND_BRANCH: begin
        e_redir = (op.alu_op == SUB) ? (res == '0) : (res != '0);
        if (e_redir) begin
          e_npc = op.pc + op.imm;
        end
      end
      KIND_JAL, KIND_JALR: begin
        wb      = 1'b1;
        e_wdata = op.pc + word_t'(4);
        e_redir = 1'b1;
        e_npc   = (op.kind == KIND_JAL) ? op.pc + op.imm : addr & ~word_t'(1);
      end
      KIND_LOAD: begin
        wb      = 1'b1;
        e_wdata = mem_m[addr[MEM_AW+1:2]];
      end
      KIND_STORE: mem_m[addr[MEM_AW+1:2]] = op.src2;
      KIND_CSR: begin
        old     = csr_read(op.csr_addr);
        wb      = 1'b1;
        e_wdata = old;
        case (op.csr_op)
          CSR_RS:  csr_write(op.csr_addr, old | op.src1);
          CSR_RC:  csr_write(op.csr_addr, old & ~op.src1);
          default: csr_write(op.csr_addr, op.src1);
        endcase
      end
      KIND_ECALL: begin
        e_redir  = 1'b1;
        e_npc    = mtvec_m;
        mepc_m   = op.pc;
        mcause_m = word_t'(`EXU_MCAUSE_ECALL);
      end
      KIND_MRET: begin
        e_redir      = 1'b1;
        e_npc        = mepc_m;
        mstatus_m[3] = mstatus_m[7];
        mstatus_m[7] = 1'b1;
      end
      default: wb = 1'b0;
    endcase
    e_rd = wb ? op.rd : '0;
    if (e_rd == '0) begin
      e_wdata = '0;
    end
  endfunction

  task automatic random_op(output op_t op);
    int unsigned r;
    int unsigned idx;
    r         = $urandom_range(0, 99);
    op.pc     = word_t'($urandom) & ~word_t'(3);
    op.src1   = word_t'($urandom);
    op.src2   = word_t'($urandom);
    op.imm    = word_t'($urandom_range(0, 255)) - word_t'(128);
    op.alu_op = alu_op_e'(4'($urandom_range(0, 11)));
    op.csr_op = csr_op_e'(2'($urandom_range(0, 2)));
    op.rd     = ($urandom_range(0, 9) == 0) ? '0 : reg_idx_t'($urandom_range(1, 31));
    case ($urandom_range(0, 4))
      0:       op.csr_addr = `EXU_CSR_MSTATUS;
      1:       op.csr_addr = `EXU_CSR_MTVEC;
      2:       op.csr_addr = `EXU_CSR_MEPC;
      3:       op.csr_addr = `EXU_CSR_MCAUSE;
      default: op.csr_addr = `EXU_CSR_MSCRATCH;
    endcase
    if (r < 30) op.kind = KIND_ALU;
    else if (r < 45) op.kind = KIND_BRANCH;
    else if (r < 50) op.kind = KIND_JAL;
    else if (r < 55) op.kind = KIND_JALR;
    else if (r < 70) op.kind = KIND_LOAD;
    else if (r < 82) op.kind = KIND_STORE;
    else if (r < 94) op.kind = KIND_CSR;
    else if (r < 97) op.kind = KIND_ECALL;
    else op.kind = KIND_MRET;
    if (op.kind == KIND_BRANCH) begin
      case ($urandom_range(0, 5))
        0:       op.alu_op = SUB;
        1:       op.alu_op = XOR;
        2:       op.alu_op = SLT;
        3:       op.alu_op = SLTU;
        4:       op.alu_op = SGE;
        default: op.alu_op = SGEU;
      endcase
      if ($urandom_range(0, 2) == 0) begin
        op.src2 = op.src1;
      end
    end
    // mostly a small window so loads hit earlier stores
    if (op.kind == KIND_LOAD || op.kind == KIND_STORE) begin
      idx     = ($urandom_range(0, 9) < 7) ? $urandom_range(0, 15)
                                           : $urandom_range(0, `EXU_MEM_WORDS - 1);
      op.src1 = (word_t'(idx) << 2) - op.imm;
    end
    if (op.kind == KIND_CSR && $urandom_range(0, 2) == 0) begin
      op.src1 = '0;
    end
  endtask

  initial begin : driver
    op_t  op;
    logic accepted;
    void'($urandom(18828));
    rst        = 1'b1;
    in_valid_i = 1'b0;
    cur_op     = '0;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int n = 0; n < NUM_OPS; n++) begin
      random_op(op);
      cur_op     = op;
      in_valid_i = 1'b1;
      accepted   = 1'b0;
      while (!accepted) begin
        @(negedge clk);
        if (in_ready_o) begin
          pend_q.push_back(cur_op);
          accepted = 1'b1;
        end
        @(posedge clk);
        #1;
      end
    end
    in_valid_i = 1'b0;
    wait (results == NUM_OPS);
    repeat (10) @(negedge clk);
    if (pend_q.size() == 0 && !out_valid_o) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      stop_on_error("a result is still offered after all operations retired");
    end
  end

  // about 30 percent back-pressure
  initial begin : ready_gen
    out_ready_i = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      out_ready_i = ($urandom_range(0, 99) >= 30);
    end
  end

  initial begin : compare
    op_t      op;
    reg_idx_t e_rd;
    word_t    e_wdata;
    logic     e_redir;
    word_t    e_npc;
    results    = 0;
    mstatus_m  = '0;
    mtvec_m    = word_t'(`EXU_MTVEC_RESET);
    mepc_m     = '0;
    mcause_m   = '0;
    mscratch_m = '0;
    for (int i = 0; i < `EXU_MEM_WORDS; i++) begin
      mem_m[i] = '0;
    end
    forever begin
      @(negedge clk);
      if (!rst && out_valid_o && out_ready_i) begin
        if (pend_q.size() == 0) begin
          stop_on_error("a result left the stage with no operation pending");
        end
        op = pend_q.pop_front();
        exu_model(op, e_rd, e_wdata, e_redir, e_npc);
        check_idx("rd_o", rd_o, e_rd);
        check_word("rd_wdata_o", rd_wdata_o, e_wdata);
        check_bit("redirect_o", redirect_o, e_redir);
        check_word("npc_o", npc_o, e_npc);
        results++;
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        stop_on_error($sformatf("timeout after %0d cycles with %0d results", cycles, results));
      end
    end
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+rtl
rtl/exu_pkg.sv
rtl/exu_alu.sv
rtl/exu_csr.sv
rtl/exu_data_mem.sv
rtl/exu_stage.sv
rtl/exu_top.sv
tests/tb_exu_top.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the execute stage testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f flist.f --top-module tb_exu_top -Mdir obj_dir -o sim_exu
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_exu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
